//--- eeprom_i2c_ctrl.sv
`timescale 1ns/1ps
`include "eeprom_params.svh"
`default_nettype none

module eeprom_i2c_ctrl
    import i2c_pkg::*;
(
    input  wire        CLK,
    input  wire        RESET,
    input  eep_req_t   req,
    output eep_rsp_t   rsp,
    output bit_cmd_e   bit_cmd,
    output logic [7:0] tx_byte,
    input  wire        bit_busy,
    input  wire        bit_done,
    input  wire  [7:0] rx_byte,
    input  wire        rx_ack
);

    ctrl_state_e               state;
    ctrl_state_e               next_state;
    logic                      issued;    // command out, waiting for done
    logic                      wr_op;
    logic [`EEPROM_ADDR_W-1:0] addr;
    logic [7:0]                wdata;
    logic [6:0]                dev_sel;   // control byte without r/w bit
    bit_cmd_e                  cmd_sel;
    logic [7:0]                tx_sel;
    logic                      sent_byte;

    // upper address bits pick the 256-byte block
    assign dev_sel = {`EEPROM_DEV_TYPE, addr[`EEPROM_ADDR_W-1:8]};

    always_comb begin
        cmd_sel    = BIT_NONE;
        tx_sel     = 8'h00;
        next_state = ST_IDLE;
        sent_byte  = 1'b0;
        case (state)
            ST_WR_START: begin
                cmd_sel    = BIT_START;
                next_state = ST_CTRL_WR;
            end
            ST_CTRL_WR: begin
                cmd_sel    = BIT_WRITE;
                tx_sel     = {dev_sel, 1'b0};
                next_state = ST_ADDR_WR;
                sent_byte  = 1'b1;
            end
            ST_ADDR_WR: begin
                cmd_sel    = BIT_WRITE;
                tx_sel     = addr[7:0];
                next_state = wr_op ? ST_DATA_WR : ST_RD_START;
                sent_byte  = 1'b1;
            end
            ST_DATA_WR: begin
                cmd_sel    = BIT_WRITE;
                tx_sel     = wdata;
                next_state = ST_STOP;
                sent_byte  = 1'b1;
            end
            ST_RD_START: begin
                cmd_sel    = BIT_START;
                next_state = ST_CTRL_RD;
            end
            ST_CTRL_RD: begin
                cmd_sel    = BIT_WRITE;
                tx_sel     = {dev_sel, 1'b1};
                next_state = ST_DATA_RD;
                sent_byte  = 1'b1;
            end
            ST_DATA_RD: begin
                cmd_sel    = BIT_READ_NACK;  // single byte, master ends it
                next_state = ST_STOP;
            end
            ST_STOP: begin
                cmd_sel    = BIT_STOP;
                next_state = ST_FINISH;
            end
            default: ;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state    <= ST_IDLE;
            issued   <= 1'b0;
            bit_cmd  <= BIT_NONE;
            rsp.done <= 1'b0;
            rsp.nack <= 1'b0;
        end else begin
            bit_cmd  <= BIT_NONE;
            rsp.done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (req.valid) begin
                        wr_op    <= req.write;
                        addr     <= req.addr;
                        wdata    <= req.wdata;
                        rsp.nack <= 1'b0;
                        state    <= ST_WR_START;
                    end
                end
                ST_FINISH: begin
                    rsp.done <= 1'b1;
                    state    <= ST_IDLE;
                end
                default: begin
                    if (!issued && !bit_busy) begin
                        bit_cmd <= cmd_sel;
                        tx_byte <= tx_sel;
                        issued  <= 1'b1;
                    end else if (bit_done) begin
                        issued <= 1'b0;
                        if (sent_byte && !rx_ack) begin
                            rsp.nack <= 1'b1;  // abandon, straight to stop
                            state    <= ST_STOP;
                        end else begin
                            state <= next_state;
                        end
                        if (state == ST_DATA_RD)
                            rsp.rdata <= rx_byte;
                    end
                end
            endcase
        end
    end

    a_cmd_not_busy: assert property (@(posedge CLK) disable iff (RESET)
        (bit_cmd != BIT_NONE) |-> !bit_busy);

    a_state_legal: assert property (@(posedge CLK) disable iff (RESET)
        !$isunknown(state) && (state <= ST_FINISH));

endmodule

`default_nettype wire

//--- eeprom_params.svh
`ifndef EEPROM_PARAMS_SVH
`define EEPROM_PARAMS_SVH

`default_nettype none

// 24C16 geometry, 2 KB behind an 11-bit byte address
`define EEPROM_ADDR_W 11

`define EEPROM_DEV_TYPE 4'b1010  // control byte high nibble

// CLK cycles per SCL quarter, SCL period is 4x this
`define SCL_QUARTER 2

`default_nettype wire

`endif

//--- eeprom_top.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_top
    import wb_pkg::*, i2c_pkg::*;
(
    input  wire     CLK,
    input  wire     RESET,
    input  wb_req_t wb_req,
    output wb_rsp_t wb_rsp,
    output logic    SCL,
    inout  wire     SDA
);

    eep_req_t   eep_req;
    eep_rsp_t   eep_rsp;
    bit_cmd_e   bit_cmd;
    logic [7:0] tx_byte;
    logic       bit_busy;
    logic       bit_done;
    logic [7:0] rx_byte;
    logic       rx_ack;
    logic       sda_drive_low;

    assign SDA = sda_drive_low ? 1'b0 : 1'bz;  // open drain, pull-up is external

    eeprom_wb_slave i_wb_slave (
        .CLK     (CLK),
        .RESET   (RESET),
        .wb_req  (wb_req),
        .wb_rsp  (wb_rsp),
        .eep_req (eep_req),
        .eep_rsp (eep_rsp)
    );

    eeprom_i2c_ctrl i_ctrl (
        .CLK      (CLK),
        .RESET    (RESET),
        .req      (eep_req),
        .rsp      (eep_rsp),
        .bit_cmd  (bit_cmd),
        .tx_byte  (tx_byte),
        .bit_busy (bit_busy),
        .bit_done (bit_done),
        .rx_byte  (rx_byte),
        .rx_ack   (rx_ack)
    );

    i2c_byte_shifter i_shifter (
        .CLK           (CLK),
        .RESET         (RESET),
        .cmd           (bit_cmd),
        .tx_byte       (tx_byte),
        .busy          (bit_busy),
        .done          (bit_done),
        .rx_byte       (rx_byte),
        .rx_ack        (rx_ack),
        .scl           (SCL),
        .sda_drive_low (sda_drive_low),
        .sda_in        (SDA)
    );

endmodule

`default_nettype wire

//--- eeprom_wb_slave.sv
`timescale 1ns/1ps
`include "eeprom_params.svh"
`default_nettype none

module eeprom_wb_slave
    import wb_pkg::*, i2c_pkg::*;
(
    input  wire      CLK,
    input  wire      RESET,
    input  wb_req_t  wb_req,
    output wb_rsp_t  wb_rsp,
    output eep_req_t eep_req,
    input  eep_rsp_t eep_rsp
);

    typedef enum logic [1:0] {
        WB_IDLE,
        WB_WAIT,   // transaction in flight
        WB_DONE    // answered, waiting for stb to drop
    } wb_state_e;

    wb_state_e state;
    logic      bus_req;

    assign bus_req = wb_req.cyc && wb_req.stb;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state         <= WB_IDLE;
            eep_req.valid <= 1'b0;
            wb_rsp.ack    <= 1'b0;
            wb_rsp.err    <= 1'b0;
        end else begin
            eep_req.valid <= 1'b0;
            wb_rsp.ack    <= 1'b0;
            wb_rsp.err    <= 1'b0;
            case (state)
                WB_IDLE: begin
                    if (bus_req) begin
                        eep_req.valid <= 1'b1;
                        eep_req.write <= wb_req.we;
                        eep_req.addr  <= wb_req.adr[`EEPROM_ADDR_W-1:0];
                        eep_req.wdata <= wb_req.dat;
                        state         <= WB_WAIT;
                    end
                end
                WB_WAIT: begin
                    if (eep_rsp.done) begin
                        // an aborted cycle gets no answer
                        wb_rsp.ack <= bus_req && !eep_rsp.nack;
                        wb_rsp.err <= bus_req && eep_rsp.nack;
                        wb_rsp.dat <= eep_rsp.rdata;
                        state      <= WB_DONE;
                    end
                end
                default: begin
                    if (!bus_req)
                        state <= WB_IDLE;  // rearm
                end
            endcase
        end
    end

    a_ack_err_excl: assert property (@(posedge CLK) disable iff (RESET)
        !(wb_rsp.ack && wb_rsp.err));

endmodule

`default_nettype wire

//--- flist.f
+incdir+.
wb_pkg.sv
i2c_pkg.sv
eeprom_wb_slave.sv
eeprom_i2c_ctrl.sv
i2c_byte_shifter.sv
eeprom_top.sv
i2c_eeprom_model.sv
tb_eeprom_top.sv

//--- i2c_byte_shifter.sv
`timescale 1ns/1ps
`include "eeprom_params.svh"
`default_nettype none

module i2c_byte_shifter
    import i2c_pkg::*;
(
    input  wire        CLK,
    input  wire        RESET,
    input  bit_cmd_e   cmd,
    input  wire  [7:0] tx_byte,
    output logic       busy,
    output logic       done,
    output logic [7:0] rx_byte,
    output logic       rx_ack,
    output logic       scl,
    output logic       sda_drive_low,
    input  wire        sda_in
);

    localparam int QW = (`SCL_QUARTER > 1) ? $clog2(`SCL_QUARTER) : 1;

    typedef enum logic [2:0] {
        SH_IDLE,
        SH_START,
        SH_STOP,
        SH_WRITE,
        SH_READ
    } sh_state_e;

    sh_state_e   state;
    logic [QW-1:0] qcnt;
    logic        qtick;
    logic [1:0]  phase;      // quarter within one SCL period
    logic [3:0]  bit_cnt;    // 0..7 data, 8 is the ack slot
    logic [7:0]  shreg;
    logic        master_ack;

    assign qtick = (qcnt == QW'(`SCL_QUARTER - 1));
    assign busy  = (state != SH_IDLE);

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state         <= SH_IDLE;
            qcnt          <= '0;
            phase         <= 2'd0;
            bit_cnt       <= 4'd0;
            scl           <= 1'b1;
            sda_drive_low <= 1'b0;
            done          <= 1'b0;
        end else begin
            done <= 1'b0;
            if (state == SH_IDLE) begin
                if (cmd != BIT_NONE) begin
                    qcnt       <= '0;
                    phase      <= 2'd0;
                    bit_cnt    <= 4'd0;
                    shreg      <= tx_byte;
                    master_ack <= (cmd == BIT_READ_ACK);
                    scl        <= 1'b0;  // q0 is always SCL low
                    case (cmd)
                        BIT_START: begin
                            state         <= SH_START;
                            sda_drive_low <= 1'b0;
                        end
                        BIT_STOP: begin
                            state         <= SH_STOP;
                            sda_drive_low <= 1'b1;
                        end
                        BIT_WRITE: begin
                            state         <= SH_WRITE;
                            sda_drive_low <= ~tx_byte[7];  // msb first
                        end
                        default: begin
                            state         <= SH_READ;
                            sda_drive_low <= 1'b0;
                        end
                    endcase
                end
            end else if (!qtick) begin
                qcnt <= qcnt + 1'b1;
            end else begin
                qcnt  <= '0;
                phase <= phase + 2'd1;
                unique case (phase)
                    2'd0: scl <= 1'b1;
                    2'd1: begin
                        // middle of SCL high
                        if (state == SH_START)
                            sda_drive_low <= 1'b1;
                        else if (state == SH_STOP)
                            sda_drive_low <= 1'b0;
                        else if (state == SH_WRITE && bit_cnt == 4'd8)
                            rx_ack <= ~sda_in;
                        else if (state == SH_READ && bit_cnt != 4'd8)
                            shreg <= {shreg[6:0], sda_in};
                    end
                    2'd2: begin
                        if (state != SH_STOP)
                            scl <= 1'b0;  // stop leaves SCL high
                    end
                    2'd3: begin
                        if (state == SH_START || state == SH_STOP || bit_cnt == 4'd8) begin
                            state <= SH_IDLE;
                            done  <= 1'b1;
                            if (state == SH_READ)
                                rx_byte <= shreg;
                        end else begin
                            bit_cnt <= bit_cnt + 4'd1;
                            if (state == SH_WRITE) begin
                                shreg         <= {shreg[6:0], 1'b0};
                                sda_drive_low <= (bit_cnt == 4'd7) ? 1'b0 : ~shreg[6];
                            end else begin
                                sda_drive_low <= (bit_cnt == 4'd7) ? master_ack : 1'b0;
                            end
                        end
                    end
                endcase
            end
        end
    end

    // line may only move under a high SCL as a start or stop
    a_sda_stable: assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && (sda_in != $past(sda_in)))
            |-> (state == SH_START || state == SH_STOP));

endmodule

`default_nettype wire

//--- i2c_eeprom_model.sv
`timescale 1ns/1ps
`include "eeprom_params.svh"
`default_nettype none

module i2c_eeprom_model (
    input  wire SCL,
    inout  wire SDA,
    input  wire ack_en
);

    typedef enum logic [2:0] {
        M_IDLE,
        M_CTRL,
        M_ADDR,
        M_DATA_W,
        M_DATA_R
    } model_state_e;

    logic [7:0]   mem [0:(1 << `EEPROM_ADDR_W) - 1];
    model_state_e state;
    logic [7:0]   shreg;
    logic [3:0]   bit_cnt;
    logic         in_ack;    // own ack bit on the line
    logic         sda_low;
    logic [2:0]   block;
    logic [7:0]   word;

    assign SDA = sda_low ? 1'b0 : 1'bz;

    initial begin
        state   = M_IDLE;
        shreg   = 8'h00;
        bit_cnt = 4'd0;
        in_ack  = 1'b0;
        sda_low = 1'b0;
        block   = 3'd0;
        word    = 8'h00;
        for (int i = 0; i < (1 << `EEPROM_ADDR_W); i++)
            mem[i] = i[7:0] ^ (8'h35 * i[10:8]);  // power-up contents
    end

    // start, SDA falls under a high SCL
    always @(negedge SDA) begin
        if (SCL === 1'b1) begin
            state   = M_CTRL;
            bit_cnt = 4'd0;
            in_ack  = 1'b0;
            sda_low = 1'b0;
        end
    end

    // stop
    always @(posedge SDA) begin
        if (SCL === 1'b1) begin
            state   = M_IDLE;
            in_ack  = 1'b0;
            sda_low = 1'b0;
        end
    end

    always @(posedge SCL) begin
        if (state != M_IDLE && !in_ack) begin
            if (bit_cnt < 4'd8) begin
                if (state != M_DATA_R)
                    shreg = {shreg[6:0], SDA === 1'b0 ? 1'b0 : 1'b1};
                bit_cnt = bit_cnt + 4'd1;
            end else if (state == M_DATA_R) begin
                // master ack slot
                if (SDA !== 1'b0) begin
                    state = M_IDLE;
                end else begin
                    word    = word + 8'd1;
                    shreg   = mem[{block, word}];
                    bit_cnt = 4'd0;
                end
            end
        end
    end

    always @(negedge SCL) begin
        if (in_ack) begin
            in_ack  = 1'b0;
            bit_cnt = 4'd0;
            sda_low = (state == M_DATA_R) ? ~shreg[7] : 1'b0;
        end else if (state == M_DATA_R) begin
            sda_low = (bit_cnt < 4'd8) ? ~shreg[3'd7 - bit_cnt[2:0]] : 1'b0;
        end else if (state != M_IDLE && bit_cnt == 4'd8) begin
            if (!ack_en) begin
                state = M_IDLE;  // stay silent, master sees NACK
            end else begin
                case (state)
                    M_CTRL: begin
                        if (shreg[7:4] != `EEPROM_DEV_TYPE) begin
                            state = M_IDLE;
                        end else begin
                            block = shreg[3:1];
                            if (shreg[0]) begin
                                state = M_DATA_R;
                                shreg = mem[{block, word}];
                            end else begin
                                state = M_ADDR;
                            end
                        end
                    end
                    M_ADDR: begin
                        word  = shreg;
                        state = M_DATA_W;
                    end
                    default: begin
                        mem[{block, word}] = shreg;
                        word = word + 8'd1;
                    end
                endcase
                if (state != M_IDLE) begin
                    sda_low = 1'b1;
                    in_ack  = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- i2c_pkg.sv
`include "eeprom_params.svh"
`default_nettype none

package i2c_pkg;

    typedef struct packed {
        logic                      valid;  // single clock
        logic                      write;
        logic [`EEPROM_ADDR_W-1:0] addr;
        logic [7:0]                wdata;
    } eep_req_t;

    typedef struct packed {
        logic       done;   // single clock
        logic       nack;   // some byte went unacknowledged
        logic [7:0] rdata;
    } eep_rsp_t;

    typedef enum logic [2:0] {
        BIT_NONE,
        BIT_START,
        BIT_STOP,
        BIT_WRITE,
        BIT_READ_ACK,
        BIT_READ_NACK
    } bit_cmd_e;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_WR_START,
        ST_CTRL_WR,
        ST_ADDR_WR,
        ST_DATA_WR,
        ST_RD_START,   // repeated start of a random read
        ST_CTRL_RD,
        ST_DATA_RD,
        ST_STOP,
        ST_FINISH
    } ctrl_state_e;

endpackage

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the EEPROM controller testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
    -f flist.f \
    --top-module tb_eeprom_top \
    -Mdir obj_dir \
    -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation run returned status $status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi
if ! grep -q "Simulation passed" "$LOG"; then
    echo "No verdict found in $LOG"
    exit 1
fi
exit 0

//--- tb_eeprom_top.sv
`timescale 1ns/1ps
`include "eeprom_params.svh"
`default_nettype none

module tb_eeprom_top
    import wb_pkg::*;
();

    localparam int TXN_COUNT  = 80;   // 74 accesses in the tests, rounded up
    localparam int TXN_CYCLES = 600;
    localparam int MAX_CYCLES = TXN_COUNT * TXN_CYCLES;

    logic    CLK;
    logic    RESET;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;
    logic    ack_en;
    wire     SCL;
    wire     SDA;

    logic [7:0] shadow [0:(1 << `EEPROM_ADDR_W) - 1];
    integer     seed;
    int         errors;
    int         bus_errors;
    int         cycles;
    int         start_cnt;
    int         stop_cnt;
    logic       bus_busy;

    pullup (SDA);

    eeprom_top i_eeprom_top (
        .CLK    (CLK),
        .RESET  (RESET),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .SCL    (SCL),
        .SDA    (SDA)
    );

    i2c_eeprom_model i_model (
        .SCL    (SCL),
        .SDA    (SDA),
        .ack_en (ack_en)
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: no Wishbone answer within %0d cycles", MAX_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    // bus monitor, SDA may only move under a high SCL as start or stop
    always @(SDA) begin
        if (RESET === 1'b0 && SCL === 1'b1) begin
            if (SDA === 1'b0) begin
                start_cnt = start_cnt + 1;
                bus_busy  = 1'b1;
            end else if (SDA === 1'b1) begin
                assert (bus_busy) else begin
                    bus_errors = bus_errors + 1;
                    $display("Stop condition at %0t without an open transaction", $time);
                end
                stop_cnt = stop_cnt + 1;
                bus_busy = 1'b0;
            end
        end
    end

    // starts_exp is 1 for a byte write or an early NACK, 2 for a random read
    task automatic wb_access(input logic we, input logic [11:0] adr, input logic [7:0] dat,
                             input int starts_exp,
                             output logic [7:0] rdat, output logic got_ack,
                             output logic got_err);
        int starts_before;
        int stops_before;
        starts_before = start_cnt;
        stops_before  = stop_cnt;
        @(posedge CLK);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        do
            @(negedge CLK);
        while (!(wb_rsp.ack || wb_rsp.err));
        got_ack = wb_rsp.ack;
        got_err = wb_rsp.err;
        rdat    = wb_rsp.dat;
        @(posedge CLK);
        wb_req <= '0;
        assert (start_cnt == starts_before + starts_exp && stop_cnt == stops_before + 1
                && !bus_busy) else begin
            errors++;
            $display("Error at %0t: access to %h saw %0d starts and %0d stops", $time, adr,
                     start_cnt - starts_before, stop_cnt - stops_before);
        end
    endtask

    task automatic write_byte(input logic [10:0] adr, input logic [7:0] dat);
        logic [7:0] rdat;
        logic       got_ack;
        logic       got_err;
        wb_access(1'b1, {1'b0, adr}, dat, 1, rdat, got_ack, got_err);
        assert (got_ack && !got_err) else begin
            errors++;
            $display("Error at %0t: write to %h got ack=%b err=%b", $time, adr, got_ack, got_err);
        end
        shadow[adr] = dat;
    endtask

    task automatic read_check(input logic [10:0] adr);
        logic [7:0] rdat;
        logic       got_ack;
        logic       got_err;
        wb_access(1'b0, {1'b0, adr}, 8'h00, 2, rdat, got_ack, got_err);
        assert (got_ack && !got_err) else begin
            errors++;
            $display("Error at %0t: read of %h got ack=%b err=%b", $time, adr, got_ack, got_err);
        end
        assert (rdat == shadow[adr]) else begin
            errors++;
            $display("Error at %0t: read %h gave %h, expected %h", $time, adr, rdat,
                     shadow[adr]);
        end
    endtask

    task automatic check_reset_state();
        @(negedge CLK);
        assert (SCL === 1'b1 && SDA === 1'b1 && !wb_rsp.ack && !wb_rsp.err) else begin
            errors++;
            $display("Error at %0t: idle bus after reset SCL=%b SDA=%b ack=%b err=%b",
                     $time, SCL, SDA, wb_rsp.ack, wb_rsp.err);
        end
    endtask

    task automatic write_read_roundtrip();
        write_byte(11'h123, 8'h5a);
        read_check(11'h123);
    endtask

    // each address sits in a different block or word
    task automatic distinct_block_cells();
        write_byte(11'd0, 8'h11);
        write_byte(11'd255, 8'h22);
        write_byte(11'd256, 8'h33);
        write_byte(11'd2047, 8'h44);
        read_check(11'd0);
        read_check(11'd255);
        read_check(11'd256);
        read_check(11'd2047);
    endtask

    task automatic random_write_read_pairs();
        logic [10:0] adr;
        logic [7:0]  dat;
        for (int n = 0; n < 30; n++) begin
            adr = 11'($random(seed));
            dat = 8'($random(seed));
            write_byte(adr, dat);
            read_check(adr);
        end
    endtask

    task automatic nack_gives_err();
        logic [7:0] rdat;
        logic       got_ack;
        logic       got_err;
        @(posedge CLK);
        ack_en <= 1'b0;
        wb_access(1'b1, 12'h0a5, 8'hc3, 1, rdat, got_ack, got_err);
        assert (got_err && !got_ack) else begin
            errors++;
            $display("Error at %0t: unacknowledged write gave ack=%b err=%b", $time,
                     got_ack, got_err);
        end
        wb_access(1'b0, 12'h0a5, 8'h00, 1, rdat, got_ack, got_err);
        assert (got_err && !got_ack) else begin
            errors++;
            $display("Error at %0t: unacknowledged read gave ack=%b err=%b", $time,
                     got_ack, got_err);
        end
        @(posedge CLK);
        ack_en <= 1'b1;
        write_byte(11'h0a5, 8'h3c);
        read_check(11'h0a5);
    endtask

    initial begin
        wb_req     = '0;
        ack_en     = 1'b1;
        RESET      = 1'b1;
        seed       = 32'h83e4;
        errors     = 0;
        bus_errors = 0;
        cycles     = 0;
        start_cnt  = 0;
        stop_cnt   = 0;
        bus_busy   = 1'b0;
        repeat (10) @(posedge CLK);
        RESET <= 1'b0;
        check_reset_state();
        write_read_roundtrip();
        distinct_block_cells();
        random_write_read_pairs();
        nack_gives_err();
        repeat (20) @(posedge CLK);
        $display("Errors: %0d data checks, %0d bus protocol", errors, bus_errors);
        if (errors == 0 && bus_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- wb_pkg.sv
`default_nettype none

package wb_pkg;

    localparam int WB_ADR_W = 12;
    localparam int WB_DAT_W = 8;

    // master to slave, classic cycle
    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [WB_ADR_W-1:0] adr;  // bits above the eeprom range ignored
        logic [WB_DAT_W-1:0] dat;
    } wb_req_t;

    // slave to master
    typedef struct packed {
        logic                ack;
        logic                err;  // no acknowledge from the eeprom
        logic [WB_DAT_W-1:0] dat;
    } wb_rsp_t;

endpackage

`default_nettype wire
